// ==== list.f ====
+incdir+test
design/pool_pkg.sv
design/pool_cmd_ctrl.sv
design/pool_line_buffer.sv
design/pool_max_tree.sv
design/pool_out_fifo.sv
design/pool_engine_top.sv
test/pool_tb.sv

// ==== Bender.yml ====
package:
  name: pool_engine

sources:
  - design/pool_pkg.sv
  - design/pool_cmd_ctrl.sv
  - design/pool_line_buffer.sv
  - design/pool_max_tree.sv
  - design/pool_out_fifo.sv
  - design/pool_engine_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/pool_tb.sv

// ==== test/pool_tb_model.svh ====
`ifndef POOL_TB_MODEL_SVH
`define POOL_TB_MODEL_SVH

// Current map in raster order and the results still owed for it
pool_pkg::pixel_t map_pix[];
pool_pkg::pixel_t exp_q[$];

// Random map, every pixel drawn from the seeded generator
task automatic make_map(input int rows, input int cols);
    map_pix = new[rows * cols];
    foreach (map_pix[i]) begin
        map_pix[i] = pool_pkg::pixel_t'($urandom);
    end
endtask

// Largest of the nine pixels in the window whose lower right corner is (r, c)
function automatic pool_pkg::pixel_t window_max(input int r, input int c, input int cols);
    pool_pkg::pixel_t best;
    best = '0;
    for (int dr = 0; dr < 3; dr++) begin
        for (int dc = 0; dc < 3; dc++) begin
            if (map_pix[(r - dr) * cols + (c - dc)] > best) begin
                best = map_pix[(r - dr) * cols + (c - dc)];
            end
        end
    end
    return best;
endfunction

// Interior windows in raster order
task automatic load_expected(input int rows, input int cols);
    exp_q.delete();
    for (int r = 2; r < rows; r++) begin
        for (int c = 2; c < cols; c++) begin
            exp_q.push_back(window_max(r, c, cols));
        end
    end
    exp_head = exp_q[0];
    exp_left = exp_q.size();
endtask

`endif

// ==== test/pool_tb.sv ====
`timescale 1ns/1ns

module pool_tb;

    localparam int TOTAL_PIXELS   = 5 * 6 + 12 * 64 + 3 * 3 + 4 * 10;
    localparam int TIMEOUT_CYCLES = 4 * TOTAL_PIXELS + 200;

    logic clk;
    logic rst;
    pool_pkg::pool_cmd_t opcode;
    logic opcode_valid;
    logic opcode_accept;
    logic opcode_complete;
    pool_pkg::pixel_t datain;
    logic datain_valid;
    logic datain_ready;
    pool_pkg::pixel_t dataout;
    logic dataout_valid;
    logic dataout_ready;

    pool_pkg::pixel_t exp_head;
    int exp_left;
    int errors;
    int err_mark;
    int tests_run;
    int got;
    int mark;
    int first_count;
    int done_count;
    int cycles;
    int stall_cycles;
    int hold_left;
    int pick;
    logic started;
    logic sink_random;
    logic low_seen;

    `include "pool_tb_model.svh"

    pool_engine_top dut0 (
        .clk             (clk),
        .rst             (rst),
        .opcode          (opcode),
        .opcode_valid    (opcode_valid),
        .opcode_accept   (opcode_accept),
        .opcode_complete (opcode_complete),
        .datain          (datain),
        .datain_valid    (datain_valid),
        .datain_ready    (datain_ready),
        .dataout         (dataout),
        .dataout_valid   (dataout_valid),
        .dataout_ready   (dataout_ready)
    );

    always #50 clk = ~clk;

    //////////////////////////////
    // Reporting
    //////////////////////////////

    task automatic value_error(input string name, input int exp, input int act);
        $display("ERROR t=%0t %s expected %0h got %0h", $time, name, exp, act);
        errors++;
    endtask

    task automatic note_failure(input string what);
        $display("Failure at %0t: %s", $time, what);
        errors++;
    endtask

    task automatic close_test(input int num, input string detail);
        $display("Test %0d %s: %s", num, detail, (errors == err_mark) ? "ok" : "failed");
        err_mark = errors;
        tests_run++;
    endtask

    //////////////////////////////
    // Host side drivers
    //////////////////////////////

    // Hold the command until the accept pulse, then drop it
    task automatic send_command(input int rows, input int cols);
        opcode       = '{num_rows: 16'(rows), num_cols: 16'(cols)};
        opcode_valid = 1'b1;
        started      = 1'b1;
        while (!opcode_accept) begin
            @(posedge clk);
            #10;
        end
        @(posedge clk);
        #10;
        opcode_valid = 1'b0;
    endtask

    // datain_ready only changes on a clock edge, so it is read mid cycle
    task automatic stream_map(input int rows, input int cols);
        int idx;
        idx = 0;
        while (idx < rows * cols) begin
            datain       = map_pix[idx];
            datain_valid = 1'b1;
            if (datain_ready) begin
                idx++;
            end
            @(posedge clk);
            #10;
        end
        datain_valid = 1'b0;
    endtask

    task automatic wait_complete();
        int start_count;
        start_count = done_count;
        while (done_count == start_count) begin
            @(posedge clk);
            #10;
        end
    endtask

    //////////////////////////////
    // Sink, watchdog and trackers
    //////////////////////////////

    // Random mode mixes short gaps with an occasional 20 cycle stall
    always @(posedge clk) begin
        #10;
        if (!sink_random) begin
            dataout_ready = 1'b1;
        end else if (hold_left > 0) begin
            dataout_ready = 1'b0;
            hold_left--;
        end else begin
            pick = $urandom % 32;
            hold_left = (pick == 0) ? 20 : 0;
            dataout_ready = (pick % 4 != 0);
        end
    end

    always @(posedge clk) begin
        if (!rst && dataout_valid && dataout_ready && exp_q.size() > 0) begin
            void'(exp_q.pop_front());
            exp_head <= (exp_q.size() > 0) ? exp_q[0] : '0;
            exp_left <= exp_q.size();
            got      <= got + 1;
        end
        if (!rst && opcode_complete) begin
            done_count <= done_count + 1;
        end
        stall_cycles <= (dataout_valid && !dataout_ready) ? stall_cycles + 1 : 0;
        if (stall_cycles >= 16 && !datain_ready) begin
            low_seen <= 1'b1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    a_idle_accept: assert property (@(posedge clk) disable iff (rst)
        !started |-> !opcode_accept
    ) else value_error("opcode_accept", 0, $sampled(opcode_accept));

    a_idle_complete: assert property (@(posedge clk) disable iff (rst)
        !started |-> !opcode_complete
    ) else value_error("opcode_complete", 0, $sampled(opcode_complete));

    a_idle_ready: assert property (@(posedge clk) disable iff (rst)
        !started |-> !datain_ready
    ) else value_error("datain_ready", 0, $sampled(datain_ready));

    a_idle_out: assert property (@(posedge clk) disable iff (rst)
        !started |-> !dataout_valid
    ) else value_error("dataout_valid", 0, $sampled(dataout_valid));

    a_accept_delay: assert property (@(posedge clk) disable iff (rst)
        $rose(opcode_valid) |=> opcode_accept
    ) else value_error("opcode_accept", 1, $sampled(opcode_accept));

    a_accept_once: assert property (@(posedge clk) disable iff (rst)
        opcode_accept |=> !opcode_accept
    ) else value_error("opcode_accept", 0, $sampled(opcode_accept));

    a_out_expected: assert property (@(posedge clk) disable iff (rst)
        dataout_valid |-> exp_left > 0
    ) else note_failure("result offered when none was expected");

    a_out_value: assert property (@(posedge clk) disable iff (rst)
        dataout_valid && dataout_ready |-> dataout == exp_head
    ) else value_error("dataout", $sampled(exp_head), $sampled(dataout));

    // Completion one cycle after the final pop
    a_complete_delay: assert property (@(posedge clk) disable iff (rst)
        dataout_valid && dataout_ready && exp_left == 1 |=> opcode_complete
    ) else value_error("opcode_complete", 1, $sampled(opcode_complete));

    a_complete_once: assert property (@(posedge clk) disable iff (rst)
        opcode_complete |=> !opcode_complete
    ) else value_error("opcode_complete", 0, $sampled(opcode_complete));

    a_complete_all: assert property (@(posedge clk) disable iff (rst)
        opcode_complete |-> exp_left == 0
    ) else note_failure("job completed with results still missing");

    a_stall_ready: assert property (@(posedge clk) disable iff (rst)
        stall_cycles >= 16 |-> !datain_ready
    ) else value_error("datain_ready", 0, $sampled(datain_ready));

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        void'($urandom(32'hd7f0204f));
        clk = 1'b0;
        rst = 1'b1;
        opcode = '0;
        opcode_valid = 1'b0;
        datain = '0;
        datain_valid = 1'b0;
        dataout_ready = 1'b1;
        exp_head = '0;
        {exp_left, errors, err_mark, tests_run, got, mark} = '0;
        {done_count, cycles, stall_cycles, hold_left, pick, first_count} = '0;
        {started, sink_random, low_seen} = '0;
        repeat (8) @(posedge clk);
        #10;
        rst = 1'b0;

        repeat (10) @(posedge clk);
        #10;
        close_test(1, "idle after reset");

        make_map(5, 6);
        load_expected(5, 6);
        send_command(5, 6);
        close_test(2, "accept pulse");

        mark = got;
        stream_map(5, 6);
        wait_complete();
        close_test(3, $sformatf("5x6 map, %0d results", got - mark));

        repeat (6) @(posedge clk);
        #10;
        close_test(4, $sformatf("completion, %0d pulse", done_count));

        make_map(12, 64);
        load_expected(12, 64);
        sink_random = 1'b1;
        mark = got;
        send_command(12, 64);
        stream_map(12, 64);
        wait_complete();
        sink_random = 1'b0;
        if (!low_seen) begin
            note_failure("datain_ready never dropped during a long output stall");
        end
        close_test(5, $sformatf("12x64 map with stalls, %0d results", got - mark));

        make_map(3, 3);
        load_expected(3, 3);
        mark = got;
        send_command(3, 3);
        stream_map(3, 3);
        wait_complete();
        first_count = got - mark;
        make_map(4, 10);
        load_expected(4, 10);
        mark = got;
        send_command(4, 10);
        stream_map(4, 10);
        wait_complete();
        close_test(6, $sformatf("back to back, %0d and %0d results", first_count, got - mark));

        $display("Tests run: %0d, errors: %0d", tests_run, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== design/pool_engine_top.sv ====
`timescale 1ns/1ns

module pool_engine_top (
    input  logic                clk,
    input  logic                rst,
    input  pool_pkg::pool_cmd_t opcode,
    input  logic                opcode_valid,
    output logic                opcode_accept,
    output logic                opcode_complete,
    input  pool_pkg::pixel_t    datain,
    input  logic                datain_valid,
    output logic                datain_ready,
    output pool_pkg::pixel_t    dataout,
    output logic                dataout_valid,
    input  logic                dataout_ready
);

    logic               pix_take;
    pool_pkg::map_pos_t pos;
    pool_pkg::window_t  win;
    logic               win_valid;
    pool_pkg::pixel_t   result;
    logic               result_valid;
    logic               room;
    logic               pop;

    pool_cmd_ctrl u_cmd_ctrl (
        .clk             (clk),
        .rst             (rst),
        .opcode          (opcode),
        .opcode_valid    (opcode_valid),
        .datain_valid    (datain_valid),
        .room            (room),
        .pop             (pop),
        .opcode_accept   (opcode_accept),
        .opcode_complete (opcode_complete),
        .datain_ready    (datain_ready),
        .pix_take        (pix_take),
        .pos             (pos)
    );

    pool_line_buffer u_line_buffer (
        .clk       (clk),
        .rst       (rst),
        .pix_take  (pix_take),
        .pos       (pos),
        .pixel     (datain),
        .win       (win),
        .win_valid (win_valid)
    );

    pool_max_tree u_max_tree (
        .clk          (clk),
        .rst          (rst),
        .win          (win),
        .win_valid    (win_valid),
        .result       (result),
        .result_valid (result_valid)
    );

    // Each new window claims its FIFO slot up front
    pool_out_fifo u_out_fifo (
        .clk           (clk),
        .rst           (rst),
        .result        (result),
        .result_valid  (result_valid),
        .reserve       (win_valid),
        .dataout_ready (dataout_ready),
        .dataout       (dataout),
        .dataout_valid (dataout_valid),
        .room          (room),
        .pop           (pop)
    );

endmodule

// ==== design/pool_out_fifo.sv ====
`timescale 1ns/1ns

module pool_out_fifo (
    input  logic             clk,
    input  logic             rst,
    input  pool_pkg::pixel_t result,
    input  logic             result_valid,
    input  logic             reserve,
    input  logic             dataout_ready,
    output pool_pkg::pixel_t dataout,
    output logic             dataout_valid,
    output logic             room,
    output logic             pop
);

    pool_pkg::pixel_t   mem [pool_pkg::OUT_DEPTH];
    pool_pkg::out_ptr_t wr_ptr;
    pool_pkg::out_ptr_t rd_ptr;
    pool_pkg::out_cnt_t count;
    pool_pkg::out_cnt_t reserved;
    logic               full;

    //////////////////////////////
    // Output side
    //////////////////////////////

    // Head entry is visible as soon as it is written
    assign dataout       = mem[rd_ptr];
    assign dataout_valid = (count != '0);
    assign pop           = dataout_valid && dataout_ready;
    assign full          = (count == pool_pkg::out_cnt_t'(pool_pkg::OUT_DEPTH));

    // One slot kept back for a window already registered in the line buffer
    assign room = (reserved < pool_pkg::out_cnt_t'(pool_pkg::OUT_DEPTH - 1));

    always_ff @(posedge clk) begin
        if (result_valid) begin
            mem[wr_ptr] <= result;
        end
    end

    //////////////////////////////
    // Pointers and counters
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            reserved <= '0;
        end else begin
            if (result_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({result_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // Slot is claimed when the window forms, freed when its result leaves
            case ({reserve, pop})
                2'b10:   reserved <= reserved + 1'b1;
                2'b01:   reserved <= reserved - 1'b1;
                default: reserved <= reserved;
            endcase
        end
    end

    a_no_write_when_full: assert property (
        @(posedge clk) disable iff (rst) result_valid |-> !full
    ) else $error("result written into a full FIFO");

    a_reserve_bound: assert property (
        @(posedge clk) disable iff (rst)
        reserved <= pool_pkg::out_cnt_t'(pool_pkg::OUT_DEPTH)
    ) else $error("more windows in flight than FIFO slots");

endmodule

// ==== design/pool_max_tree.sv ====
`timescale 1ns/1ns

module pool_max_tree (
    input  logic              clk,
    input  logic              rst,
    input  pool_pkg::window_t win,
    input  logic              win_valid,
    output pool_pkg::pixel_t  result,
    output logic              result_valid
);

    pool_pkg::pixel_t row_max [3];
    logic             s1_valid;

    function automatic pool_pkg::pixel_t max2(
        input pool_pkg::pixel_t a,
        input pool_pkg::pixel_t b
    );
        return (a > b) ? a : b;
    endfunction

    function automatic pool_pkg::pixel_t max3(input pool_pkg::win_row_t r);
        return max2(max2(r[0], r[1]), r[2]);
    endfunction

    //////////////////////////////
    // Stage 1, per row
    //////////////////////////////

    always_ff @(posedge clk) begin
        row_max[0] <= max3(win.row0);
        row_max[1] <= max3(win.row1);
        row_max[2] <= max3(win.row2);
    end

    //////////////////////////////
    // Stage 2, across rows
    //////////////////////////////

    always_ff @(posedge clk) begin
        result <= max2(max2(row_max[0], row_max[1]), row_max[2]);
    end

    // Valid follows the data, no stall since the FIFO slot is reserved
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid     <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            s1_valid     <= win_valid;
            result_valid <= s1_valid;
        end
    end

endmodule

// ==== design/pool_line_buffer.sv ====
`timescale 1ns/1ns

module pool_line_buffer (
    input  logic               clk,
    input  logic               rst,
    input  logic               pix_take,
    input  pool_pkg::map_pos_t pos,
    input  pool_pkg::pixel_t   pixel,
    output pool_pkg::window_t  win,
    output logic               win_valid
);

    // Lower memory holds the previous row, upper memory the one before it
    pool_pkg::pixel_t mem_lo [pool_pkg::MAX_COLS];
    pool_pkg::pixel_t mem_hi [pool_pkg::MAX_COLS];

    pool_pkg::pixel_t lo_rd;
    pool_pkg::pixel_t hi_rd;
    logic             interior;

    //////////////////////////////
    // Column sample
    //////////////////////////////

    // Same column, one and two rows up
    assign lo_rd = mem_lo[pos.col];
    assign hi_rd = mem_hi[pos.col];

    // Full 3x3 neighborhood exists only from row 2 and column 2 on
    assign interior = (pos.row >= pool_pkg::ROW_W'(2)) &&
                      (pos.col >= pool_pkg::COL_W'(2));

    //////////////////////////////
    // Row memories
    //////////////////////////////

    // Each take pushes the column down by one row
    always_ff @(posedge clk) begin
        if (pix_take) begin
            mem_lo[pos.col] <= pixel;
            mem_hi[pos.col] <= lo_rd;
        end
    end

    //////////////////////////////
    // Window shift array
    //////////////////////////////

    // New column enters at index 0, oldest column drops off index 2
    always_ff @(posedge clk) begin
        if (pix_take) begin
            win.row0 <= {win.row0[1:0], hi_rd};
            win.row1 <= {win.row1[1:0], lo_rd};
            win.row2 <= {win.row2[1:0], pixel};
        end
    end

    // One pulse per completed interior window
    always_ff @(posedge clk) begin
        if (rst) begin
            win_valid <= 1'b0;
        end else begin
            win_valid <= pix_take && interior;
        end
    end

endmodule

// ==== design/pool_cmd_ctrl.sv ====
`timescale 1ns/1ns

module pool_cmd_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  pool_pkg::pool_cmd_t opcode,
    input  logic                opcode_valid,
    input  logic                datain_valid,
    input  logic                room,
    input  logic                pop,
    output logic                opcode_accept,
    output logic                opcode_complete,
    output logic                datain_ready,
    output logic                pix_take,
    output pool_pkg::map_pos_t  pos
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACCEPT,
        ST_BUSY
    } state_t;

    state_t              state;
    pool_pkg::pool_cmd_t cmd_q;
    logic [15:0]         res_total;
    logic [15:0]         res_count;
    logic                in_done;
    logic                last_col;
    logic                last_row;
    logic                last_pop;

    //////////////////////////////
    // Handshakes
    //////////////////////////////

    assign opcode_accept = (state == ST_ACCEPT);
    // Stop taking pixels once the map is in, or when the FIFO has no spare slot
    assign datain_ready  = (state == ST_BUSY) && !in_done && room;
    assign pix_take      = datain_valid && datain_ready;

    assign last_col = (16'(pos.col) == cmd_q.num_cols - 16'd1);
    assign last_row = (16'(pos.row) == cmd_q.num_rows - 16'd1);
    assign last_pop = (res_count == res_total - 16'd1);

    // Command held for the whole job
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && opcode_valid) begin
            cmd_q <= opcode;
        end
        // Interior window count, fits in 16 bits for the largest map
        if (state == ST_ACCEPT) begin
            res_total <= (cmd_q.num_rows - 16'd2) * (cmd_q.num_cols - 16'd2);
        end
    end

    //////////////////////////////
    // FSM and raster counters
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state           <= ST_IDLE;
            opcode_complete <= 1'b0;
            pos             <= '0;
            res_count       <= '0;
            in_done         <= 1'b0;
        end else begin
            opcode_complete <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (opcode_valid) begin
                        state <= ST_ACCEPT;
                    end
                end
                ST_ACCEPT: begin
                    pos       <= '0;
                    res_count <= '0;
                    in_done   <= 1'b0;
                    state     <= ST_BUSY;
                end
                ST_BUSY: begin
                    if (pix_take) begin
                        if (last_col) begin
                            pos.col <= '0;
                            pos.row <= pos.row + 1'b1;
                            in_done <= last_row;
                        end else begin
                            pos.col <= pos.col + 1'b1;
                        end
                    end
                    // Job ends when the final result leaves the FIFO
                    if (pop) begin
                        res_count <= res_count + 16'd1;
                        if (last_pop) begin
                            opcode_complete <= 1'b1;
                            state           <= ST_IDLE;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    a_accept_complete_apart: assert property (
        @(posedge clk) disable iff (rst) !(opcode_accept && opcode_complete)
    ) else $error("opcode_accept and opcode_complete high together");

endmodule

// ==== design/pool_pkg.sv ====
package pool_pkg;

    //////////////////////////////
    // Sizing
    //////////////////////////////

    localparam int PIXEL_W   = 16;
    // Widest supported map, one row memory entry per column
    localparam int MAX_COLS  = 64;
    localparam int COL_W     = 6;
    localparam int ROW_W     = 10;
    localparam int OUT_DEPTH = 8;
    localparam int OUT_AW    = $clog2(OUT_DEPTH);
    // One extra bit so a full FIFO can be counted
    localparam int OUT_CNT_W = OUT_AW + 1;

    //////////////////////////////
    // Types
    //////////////////////////////

    typedef logic [PIXEL_W-1:0] pixel_t;

    // Three columns of one window row, index 0 is the newest column
    typedef pixel_t [2:0] win_row_t;

    typedef logic [OUT_AW-1:0]    out_ptr_t;
    typedef logic [OUT_CNT_W-1:0] out_cnt_t;

    typedef struct packed {
        logic [15:0] num_rows;
        logic [15:0] num_cols;
    } pool_cmd_t;

    // Oldest row first
    typedef struct packed {
        win_row_t row0;
        win_row_t row1;
        win_row_t row2;
    } window_t;

    typedef struct packed {
        logic [ROW_W-1:0] row;
        logic [COL_W-1:0] col;
    } map_pos_t;

endpackage
